//--- axis_rd_pkg.sv
package axis_rd_pkg;

   // Bus widths
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int AXI_LEN_W  = 8;

   // Burst limits
   localparam int BURST_W    = 4;
   localparam int MAX_BURST  = 2 ** BURST_W;
   localparam int PAGE_BYTES = 4096;
   localparam int BEAT_BYTES = AXI_DATA_W / 8;

   typedef logic [AXI_ADDR_W-1:0] addr_t;
   typedef logic [31:0]           wlen_t;

   // Holds 0 to MAX_BURST inclusive
   typedef logic [BURST_W:0]      beats_t;

   typedef logic [AXI_DATA_W-1:0] data_t;
   typedef logic [AXI_LEN_W-1:0]  axlen_t;

   // Job and burst sequencing
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      PLAN = 2'd1,
      ADDR = 2'd2,
      DATA = 2'd3
   } ctrl_state_t;

endpackage

//--- axis_rd_burst_if.sv
`timescale 1ns/10ps

interface axis_rd_burst_if;

   // Strobes from the FSM
   logic                  load;
   logic                  plan;
   logic                  advance;

   // Job progress
   axis_rd_pkg::addr_t    cur_addr;
   axis_rd_pkg::wlen_t    remaining;
   logic                  job_done;

   // Size of the next burst
   axis_rd_pkg::beats_t   burst_beats;

   modport ctrl (
      output load, plan, advance,
      input  job_done
   );

   modport gen (
      output cur_addr, remaining, job_done,
      input  load, plan, advance, burst_beats
   );

   modport calc (
      output burst_beats,
      input  cur_addr, remaining
   );

   modport issue (
      input plan, cur_addr, burst_beats
   );

endinterface

//--- axis_rd_ctrl.sv
`timescale 1ns/10ps

module axis_rd_ctrl (
   input  logic               clk_i,
   input  logic               rst_i,

   input  logic               cfg_valid_i,
   input  axis_rd_pkg::wlen_t cfg_len_i,
   output logic               cfg_ready_o,

   input  logic               m_arready_i,
   input  logic               m_rvalid_i,
   input  logic               m_rlast_i,
   output logic               m_rready_o,

   output logic               axis_valid_o,
   input  logic               axis_ready_i,

   axis_rd_burst_if.ctrl      bif_i
);

   axis_rd_pkg::ctrl_state_t state;
   axis_rd_pkg::ctrl_state_t state_nxt;

   logic cfg_accept;
   logic len_zero;
   logic in_data;
   logic r_accept;
   logic last_accept;

   assign len_zero   = (cfg_len_i == '0);
   assign cfg_accept = cfg_valid_i && cfg_ready_o;
   assign in_data    = (state == axis_rd_pkg::DATA);

   // R channel only opens while a burst is in flight
   assign axis_valid_o = in_data && m_rvalid_i;
   assign m_rready_o   = in_data && axis_ready_i;

   assign r_accept    = m_rvalid_i && m_rready_o;
   assign last_accept = r_accept && m_rlast_i;

   assign cfg_ready_o = (state == axis_rd_pkg::IDLE);

   // Strobes to the datapath
   assign bif_i.load    = cfg_accept;
   assign bif_i.plan    = (state == axis_rd_pkg::PLAN);
   assign bif_i.advance = last_accept;

   always_comb begin
      state_nxt = state;

      case (state)
         axis_rd_pkg::IDLE: begin
            // Zero-length jobs are taken and dropped here
            if (cfg_accept && !len_zero) begin
               state_nxt = axis_rd_pkg::PLAN;
            end
         end

         axis_rd_pkg::PLAN: begin
            state_nxt = axis_rd_pkg::ADDR;
         end

         axis_rd_pkg::ADDR: begin
            if (m_arready_i) begin
               state_nxt = axis_rd_pkg::DATA;
            end
         end

         axis_rd_pkg::DATA: begin
            if (last_accept) begin
               // remaining was already reduced when this burst was planned
               if (bif_i.job_done) begin
                  state_nxt = axis_rd_pkg::IDLE;
               end else begin
                  state_nxt = axis_rd_pkg::PLAN;
               end
            end
         end

         default: begin
            state_nxt = axis_rd_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= axis_rd_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

//--- axis_rd_burst_calc.sv
`timescale 1ns/10ps

module axis_rd_burst_calc (
   axis_rd_burst_if.calc bif_i
);

   localparam int PAGE_OFS_W = $clog2(axis_rd_pkg::PAGE_BYTES);
   localparam int BEAT_SH    = $clog2(axis_rd_pkg::BEAT_BYTES);

   // One extra bit so a full page fits
   logic [PAGE_OFS_W:0]         page_left_bytes;
   logic [PAGE_OFS_W-BEAT_SH:0] page_left_words;

   axis_rd_pkg::beats_t len_beats;
   axis_rd_pkg::beats_t page_beats;

   // Bytes up to the next 4 KB boundary
   assign page_left_bytes = (PAGE_OFS_W + 1)'(axis_rd_pkg::PAGE_BYTES)
                          - {1'b0, bif_i.cur_addr[PAGE_OFS_W-1:0]};
   assign page_left_words = page_left_bytes[PAGE_OFS_W:BEAT_SH];

   // Limit by job length first
   always_comb begin
      if (bif_i.remaining >= axis_rd_pkg::wlen_t'(axis_rd_pkg::MAX_BURST)) begin
         len_beats = axis_rd_pkg::beats_t'(axis_rd_pkg::MAX_BURST);
      end else begin
         len_beats = bif_i.remaining[axis_rd_pkg::BURST_W:0];
      end
   end

   // Then by the page boundary
   always_comb begin
      if (page_left_words < (PAGE_OFS_W - BEAT_SH + 1)'(len_beats)) begin
         page_beats = axis_rd_pkg::beats_t'(page_left_words);
      end else begin
         page_beats = len_beats;
      end
   end

   assign bif_i.burst_beats = page_beats;

endmodule

//--- axis_rd_addr_gen.sv
`timescale 1ns/10ps

module axis_rd_addr_gen (
   input  logic               clk_i,
   input  logic               rst_i,

   input  axis_rd_pkg::addr_t cfg_addr_i,
   input  axis_rd_pkg::wlen_t cfg_len_i,

   axis_rd_burst_if.gen       bif_i
);

   axis_rd_pkg::addr_t  cur_addr;
   axis_rd_pkg::wlen_t  remaining;
   axis_rd_pkg::beats_t planned;

   axis_rd_pkg::addr_t  burst_bytes;

   // Byte span of the burst in flight
   assign burst_bytes = axis_rd_pkg::addr_t'(planned)
                      * axis_rd_pkg::addr_t'(axis_rd_pkg::BEAT_BYTES);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         remaining <= '0;
      end else if (bif_i.load) begin
         remaining <= cfg_len_i;
      end else if (bif_i.plan) begin
         remaining <= remaining - axis_rd_pkg::wlen_t'(bif_i.burst_beats);
      end
   end

   always_ff @(posedge clk_i) begin
      if (bif_i.load) begin
         cur_addr <= cfg_addr_i;
      end else if (bif_i.advance) begin
         cur_addr <= cur_addr + burst_bytes;
      end
   end

   // Kept until rlast so the address can step past the burst
   always_ff @(posedge clk_i) begin
      if (bif_i.plan) begin
         planned <= bif_i.burst_beats;
      end
   end

   assign bif_i.cur_addr  = cur_addr;
   assign bif_i.remaining = remaining;
   assign bif_i.job_done  = (remaining == '0);

endmodule

//--- axis_rd_ar_issue.sv
`timescale 1ns/10ps

module axis_rd_ar_issue (
   input  logic                clk_i,
   input  logic                rst_i,

   output axis_rd_pkg::addr_t  m_araddr_o,
   output axis_rd_pkg::axlen_t m_arlen_o,
   output logic                m_arvalid_o,
   input  logic                m_arready_i,

   axis_rd_burst_if.issue      bif_i
);

   axis_rd_pkg::addr_t  araddr;
   axis_rd_pkg::axlen_t arlen;
   logic                arvalid;

   // Request fields change only on plan
   always_ff @(posedge clk_i) begin
      if (bif_i.plan) begin
         araddr <= bif_i.cur_addr;
         arlen  <= axis_rd_pkg::axlen_t'(bif_i.burst_beats - axis_rd_pkg::beats_t'(1));
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         arvalid <= 1'b0;
      end else if (bif_i.plan) begin
         arvalid <= 1'b1;
      end else if (m_arready_i) begin
         // Drops on the accepting edge
         arvalid <= 1'b0;
      end
   end

   assign m_araddr_o  = araddr;
   assign m_arlen_o   = arlen;
   assign m_arvalid_o = arvalid;

endmodule

//--- axis_rd_top.sv
`timescale 1ns/10ps

module axis_rd_top (
   input  logic                clk_i,
   input  logic                rst_i,

   // Job configuration
   input  axis_rd_pkg::addr_t  cfg_addr_i,
   input  axis_rd_pkg::wlen_t  cfg_len_i,
   input  logic                cfg_valid_i,
   output logic                cfg_ready_o,

   // AXI read address
   output axis_rd_pkg::addr_t  m_araddr_o,
   output axis_rd_pkg::axlen_t m_arlen_o,
   output logic                m_arvalid_o,
   input  logic                m_arready_i,

   // AXI read data
   input  axis_rd_pkg::data_t  m_rdata_i,
   input  logic                m_rvalid_i,
   input  logic                m_rlast_i,
   output logic                m_rready_o,

   // Output stream
   output axis_rd_pkg::data_t  axis_data_o,
   output logic                axis_valid_o,
   input  logic                axis_ready_i
);

   axis_rd_burst_if i_burst_if ();

   axis_rd_ctrl i_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cfg_valid_i  (cfg_valid_i),
      .cfg_len_i    (cfg_len_i),
      .cfg_ready_o  (cfg_ready_o),
      .m_arready_i  (m_arready_i),
      .m_rvalid_i   (m_rvalid_i),
      .m_rlast_i    (m_rlast_i),
      .m_rready_o   (m_rready_o),
      .axis_valid_o (axis_valid_o),
      .axis_ready_i (axis_ready_i),
      .bif_i        (i_burst_if.ctrl)
   );

   axis_rd_burst_calc i_burst_calc (
      .bif_i (i_burst_if.calc)
   );

   axis_rd_addr_gen i_addr_gen (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_len_i  (cfg_len_i),
      .bif_i      (i_burst_if.gen)
   );

   axis_rd_ar_issue i_ar_issue (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .m_araddr_o  (m_araddr_o),
      .m_arlen_o   (m_arlen_o),
      .m_arvalid_o (m_arvalid_o),
      .m_arready_i (m_arready_i),
      .bif_i       (i_burst_if.issue)
   );

   // Read data goes straight to the stream
   assign axis_data_o = m_rdata_i;

endmodule

//--- tb_axi_mem_model.sv
`timescale 1ns/10ps

module tb_axi_mem_model (
   input  logic                clk_i,
   input  logic                rst_i,
   input  axis_rd_pkg::addr_t  araddr_i,
   input  axis_rd_pkg::axlen_t arlen_i,
   input  logic                arvalid_i,
   output logic                arready_o,
   output axis_rd_pkg::data_t  rdata_o,
   output logic                rvalid_o,
   output logic                rlast_o,
   input  logic                rready_i,
   output logic                rec_valid_o,
   output axis_rd_pkg::addr_t  rec_addr_o,
   output axis_rd_pkg::axlen_t rec_len_o,
   output int                  rule_errs_o
);

   localparam int          HS_LIMIT = 2000;
   localparam logic [31:0] PATTERN  = 32'h5A3C_9E17;

   integer              seed;
   int                  gap;
   int                  waited;
   int                  beat;
   axis_rd_pkg::addr_t  addr;
   axis_rd_pkg::axlen_t len;

   // Word stored at a byte address
   function automatic axis_rd_pkg::data_t mem_word(input axis_rd_pkg::addr_t a);
      return a ^ PATTERN;
   endfunction

   initial begin
      seed = 54;
      arready_o = 1'b0;
      rvalid_o = 1'b0;
      rlast_o = 1'b0;
      rdata_o = '0;
      rec_valid_o = 1'b0;
      rec_addr_o = '0;
      rec_len_o = '0;
      rule_errs_o = 0;
      forever begin
         @(negedge clk_i);
         if (!rst_i && arvalid_i) begin
            addr = araddr_i;
            len = arlen_i;
            gap = $random(seed) & 3;
            repeat (gap) @(negedge clk_i);
            // Request must stay up and unchanged while it waits
            if (!arvalid_i || araddr_i !== addr || arlen_i !== len) begin
               $display("AR request at %h changed before it was accepted", addr);
               rule_errs_o++;
            end
            arready_o = 1'b1;
            @(posedge clk_i);
            @(negedge clk_i);
            arready_o = 1'b0;
            rec_addr_o = addr;
            rec_len_o = len;
            rec_valid_o = 1'b1;
            if (int'(len) >= axis_rd_pkg::MAX_BURST) begin
               $display("Burst at %h is longer than 16 beats", addr);
               rule_errs_o++;
            end
            if (int'(addr[11:0]) + (int'(len) + 1) * 4 > axis_rd_pkg::PAGE_BYTES) begin
               $display("Burst at %h crosses a 4 KB page", addr);
               rule_errs_o++;
            end
            @(negedge clk_i);
            rec_valid_o = 1'b0;
            for (beat = 0; beat <= int'(len); beat++) begin
               gap = $random(seed) & 3;
               repeat (gap) @(negedge clk_i);
               rvalid_o = 1'b1;
               rdata_o = mem_word(addr + axis_rd_pkg::addr_t'(beat * 4));
               rlast_o = (beat == int'(len));
               waited = 0;
               @(posedge clk_i);
               while (!rready_i && waited < HS_LIMIT) begin
                  waited++;
                  @(posedge clk_i);
               end
               if (!rready_i) begin
                  $display("R beat %0d at %h was never accepted", beat, addr);
                  rule_errs_o++;
               end
               @(negedge clk_i);
               rvalid_o = 1'b0;
               rlast_o = 1'b0;
            end
         end
      end
   end

endmodule

//--- tb_axis_rd.sv
`timescale 1ns/10ps

module tb_axis_rd;

   localparam int          WAIT_LIMIT = 4000;
   localparam logic [31:0] PATTERN    = 32'h5A3C_9E17;

   logic clk_i = 1'b0;
   logic rst_i;
   axis_rd_pkg::addr_t  cfg_addr_i;
   axis_rd_pkg::wlen_t  cfg_len_i;
   logic                cfg_valid_i;
   logic                cfg_ready_o;
   axis_rd_pkg::addr_t  m_araddr_o;
   axis_rd_pkg::axlen_t m_arlen_o;
   logic                m_arvalid_o;
   logic                m_arready_i;
   axis_rd_pkg::data_t  m_rdata_i;
   logic                m_rvalid_i;
   logic                m_rlast_i;
   logic                m_rready_o;
   axis_rd_pkg::data_t  axis_data_o;
   logic                axis_valid_o;
   logic                axis_ready_i;
   logic                rec_valid;
   axis_rd_pkg::addr_t  rec_addr;
   axis_rd_pkg::axlen_t rec_len;
   int                  model_errs;

   integer seed;
   logic   bp_en;
   int     errors;
   int     test_errs;
   int     tests_run;
   int     tests_failed;
   int     rule_errs;
   int     k;
   axis_rd_pkg::addr_t  rnd_addr;
   axis_rd_pkg::wlen_t  rnd_len;

   axis_rd_pkg::data_t  got_q[$];
   axis_rd_pkg::data_t  exp_word_q[$];
   axis_rd_pkg::addr_t  rec_addr_q[$];
   axis_rd_pkg::addr_t  exp_addr_q[$];
   axis_rd_pkg::axlen_t rec_len_q[$];
   axis_rd_pkg::axlen_t exp_len_q[$];

   always #20 clk_i = ~clk_i;

   axis_rd_top i_axis_rd_top (.*);

   tb_axi_mem_model i_mem_model (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .araddr_i    (m_araddr_o),
      .arlen_i     (m_arlen_o),
      .arvalid_i   (m_arvalid_o),
      .arready_o   (m_arready_i),
      .rdata_o     (m_rdata_i),
      .rvalid_o    (m_rvalid_i),
      .rlast_o     (m_rlast_i),
      .rready_i    (m_rready_o),
      .rec_valid_o (rec_valid),
      .rec_addr_o  (rec_addr),
      .rec_len_o   (rec_len),
      .rule_errs_o (model_errs)
   );

   // Stream words and recorded bursts
   always @(posedge clk_i) begin
      if (!rst_i) begin
         if (axis_valid_o && axis_ready_i) begin
            got_q.push_back(axis_data_o);
         end
         if (rec_valid) begin
            rec_addr_q.push_back(rec_addr);
            rec_len_q.push_back(rec_len);
         end
      end
   end

   always @(negedge clk_i) begin
      axis_ready_i = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
   end

   function automatic axis_rd_pkg::data_t expected_word(input axis_rd_pkg::addr_t a);
      return a ^ PATTERN;
   endfunction

   // Bursts of at most 16 beats that stop at the page edge
   function automatic void plan_bursts(input axis_rd_pkg::addr_t addr,
                                       input axis_rd_pkg::wlen_t len);
      axis_rd_pkg::addr_t a;
      axis_rd_pkg::wlen_t rem;
      axis_rd_pkg::wlen_t n;
      axis_rd_pkg::wlen_t page_words;
      axis_rd_pkg::wlen_t i;
      a = addr;
      rem = len;
      while (rem != 0) begin
         n = (rem > 16) ? 32'd16 : rem;
         page_words = (32'd4096 - {20'd0, a[11:0]}) / 4;
         if (page_words < n) begin
            n = page_words;
         end
         exp_addr_q.push_back(a);
         exp_len_q.push_back(axis_rd_pkg::axlen_t'(n - 1));
         for (i = 0; i < n; i++) begin
            exp_word_q.push_back(expected_word(a + i * 4));
         end
         a = a + n * 4;
         rem = rem - n;
      end
   endfunction

   task automatic check_word(input string name, input axis_rd_pkg::data_t exp,
                             input axis_rd_pkg::data_t act);
      if (exp !== act) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_burst(input string name,
                              input axis_rd_pkg::addr_t ea, input axis_rd_pkg::axlen_t el,
                              input axis_rd_pkg::addr_t aa, input axis_rd_pkg::axlen_t al);
      if (ea !== aa || el !== al) begin
         $display("** Error %s: expected burst %h len %0d, actual %h len %0d",
                  name, ea, el, aa, al);
         test_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic begin_test();
      @(negedge clk_i);
      got_q.delete();
      exp_word_q.delete();
      rec_addr_q.delete();
      rec_len_q.delete();
      exp_addr_q.delete();
      exp_len_q.delete();
      test_errs = 0;
   endtask

   task automatic send_job(input axis_rd_pkg::addr_t addr, input axis_rd_pkg::wlen_t len);
      int   waited;
      logic taken;
      waited = 0;
      taken = 1'b0;
      @(negedge clk_i);
      cfg_addr_i = addr;
      cfg_len_i = len;
      cfg_valid_i = 1'b1;
      while (!taken && waited < WAIT_LIMIT) begin
         @(posedge clk_i);
         taken = cfg_ready_o;
         waited++;
      end
      @(negedge clk_i);
      cfg_valid_i = 1'b0;
      if (!taken) begin
         $display("Job at %h was never accepted", addr);
         test_errs++;
      end
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      while (!(got_q.size() >= exp_word_q.size() && cfg_ready_o) && waited < WAIT_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (waited >= WAIT_LIMIT) begin
         $display("Engine did not finish its job in time");
         test_errs++;
      end
   endtask

   task automatic do_job(input axis_rd_pkg::addr_t addr, input axis_rd_pkg::wlen_t len);
      plan_bursts(addr, len);
      send_job(addr, len);
      wait_idle();
   endtask

   task automatic end_test(input string name);
      int i;
      if (got_q.size() != exp_word_q.size()) begin
         $display("%s received %0d words, not %0d", name, got_q.size(), exp_word_q.size());
         test_errs++;
      end
      if (rec_addr_q.size() != exp_addr_q.size()) begin
         $display("%s saw %0d bursts, not %0d", name, rec_addr_q.size(), exp_addr_q.size());
         test_errs++;
      end
      for (i = 0; i < got_q.size() && i < exp_word_q.size(); i++) begin
         check_word(name, exp_word_q[i], got_q[i]);
      end
      for (i = 0; i < rec_addr_q.size() && i < exp_addr_q.size(); i++) begin
         check_burst(name, exp_addr_q[i], exp_len_q[i], rec_addr_q[i], rec_len_q[i]);
      end
      if (model_errs != rule_errs) begin
         $display("%s broke the burst rules %0d times", name, model_errs - rule_errs);
         rule_errs = model_errs;
         test_errs++;
      end
      tests_run++;
      if (test_errs == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: failed with %0d errors", name, test_errs);
         tests_failed++;
         errors += test_errs;
      end
   endtask

   task automatic back_to_back();
      int   waited;
      logic taken;
      waited = 0;
      taken = 1'b0;
      plan_bursts(32'h0000_3000, 20);
      plan_bursts(32'h0000_5FF0, 9);
      send_job(32'h0000_3000, 20);
      cfg_addr_i = 32'h0000_5FF0;
      cfg_len_i = 9;
      cfg_valid_i = 1'b1;
      while (!taken && waited < WAIT_LIMIT) begin
         @(posedge clk_i);
         if (got_q.size() < 20) begin
            check_flag("back_to_back cfg_ready", 1'b0, cfg_ready_o);
         end
         taken = cfg_ready_o;
         waited++;
      end
      @(negedge clk_i);
      cfg_valid_i = 1'b0;
      if (!taken) begin
         $display("Second job was never accepted");
         test_errs++;
      end
      wait_idle();
   endtask

   initial begin
      seed = 54;
      bp_en = 1'b0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      rule_errs = 0;
      rst_i = 1'b1;
      cfg_addr_i = '0;
      cfg_len_i = '0;
      cfg_valid_i = 1'b0;
      axis_ready_i = 1'b1;
      repeat (8) @(posedge clk_i);
      begin_test();
      check_flag("reset arvalid", 1'b0, m_arvalid_o);
      check_flag("reset rready", 1'b0, m_rready_o);
      check_flag("reset axis_valid", 1'b0, axis_valid_o);
      check_flag("reset cfg_ready", 1'b1, cfg_ready_o);
      rst_i = 1'b0;
      end_test("reset");

      begin_test();
      do_job(32'h0000_0100, 3);
      end_test("short_aligned");

      begin_test();
      do_job(32'h0000_2000, 40);
      end_test("long_job");

      begin_test();
      do_job(32'h0000_0FF8, 10);
      end_test("page_crossing");

      begin_test();
      send_job(32'h0000_0200, 0);
      repeat (40) begin
         @(negedge clk_i);
         check_flag("zero_len arvalid", 1'b0, m_arvalid_o);
         check_flag("zero_len cfg_ready", 1'b1, cfg_ready_o);
      end
      end_test("zero_length");

      begin_test();
      bp_en = 1'b1;
      for (k = 0; k < 6; k++) begin
         rnd_addr = axis_rd_pkg::addr_t'($random(seed)) & 32'h0000_3FFC;
         rnd_len = axis_rd_pkg::wlen_t'(($random(seed) & 63) + 1);
         do_job(rnd_addr, rnd_len);
      end
      bp_en = 1'b0;
      end_test("backpressure");

      begin_test();
      back_to_back();
      end_test("back_to_back");

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
axis_rd_pkg.sv
axis_rd_burst_if.sv
axis_rd_ctrl.sv
axis_rd_burst_calc.sv
axis_rd_addr_gen.sv
axis_rd_ar_issue.sv
axis_rd_top.sv
tb_axi_mem_model.sv
tb_axis_rd.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_axis_rd -f flist.f -o sim_axis_rd &&
./obj_dir/sim_axis_rd | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
